/* ram64x1d.sv */
`timescale 1ns/1ps

module ram64x1d (
    input  logic       clk,
    input  logic [5:0] a_addr,
    input  logic       a_wrdata,
    input  logic       a_wren,
    output logic       a_rddata,
    input  logic [5:0] b_addr,
    output logic       b_rddata
);

    logic mem [64];

    always_ff @(posedge clk) begin
        if (a_wren)
            mem[a_addr] <= a_wrdata;
    end

    assign a_rddata = mem[a_addr];
    assign b_rddata = mem[b_addr];   // Video side read

endmodule

/* sprattr.sv */
`timescale 1ns/1ps

module sprattr (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [3:0]                       io_addr,
    input  logic [7:0]                       io_wrdata,
    input  logic                             io_wren,
    output logic [7:0]                       io_rddata,
    input  logic [sprite_pkg::SPR_SEL_W-1:0] spr_sel,
    output sprite_pkg::spr_attr_t            spr_attr
);

    import sprite_pkg::*;

    logic [SPR_SEL_W-1:0] sprsel_r;
    logic [ATTR_BITS-1:0] a_wrdata;
    logic [ATTR_BITS-1:0] a_wren;
    wire  [ATTR_BITS-1:0] a_rddata;
    wire  [ATTR_BITS-1:0] b_rddata;
    spr_attr_t            a_attr;
    logic                 wren_x_l;
    logic                 wren_x_h;
    logic                 wren_y;
    logic                 wren_idx;
    logic                 wren_attr;

    assign wren_x_l  = io_wren && io_addr == REG_SPRX_L;
    assign wren_x_h  = io_wren && io_addr == REG_SPRX_H;
    assign wren_y    = io_wren && io_addr == REG_SPRY;
    assign wren_idx  = io_wren && io_addr == REG_SPRIDX;
    assign wren_attr = io_wren && io_addr == REG_SPRATTR;

    // Same byte lands in each field, enables pick the field
    assign a_wrdata = {io_wrdata, io_wrdata, io_wrdata, io_wrdata[0], io_wrdata};
    assign a_wren   = {{8{wren_attr}}, {8{wren_idx}}, {8{wren_y}}, wren_x_h, {8{wren_x_l}}};

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            sprsel_r <= '0;
        else if (io_wren && io_addr == REG_SPRSEL)
            sprsel_r <= io_wrdata[SPR_SEL_W-1:0];
    end

    assign a_attr = a_rddata;

    always_comb begin
        case (io_addr)
            REG_SPRSEL:  io_rddata = {2'b00, sprsel_r};
            REG_SPRX_L:  io_rddata = a_attr.x[7:0];
            REG_SPRX_H:  io_rddata = {7'b0, a_attr.x[8]};
            REG_SPRY:    io_rddata = a_attr.y;
            REG_SPRIDX:  io_rddata = a_attr.idx[7:0];
            REG_SPRATTR: io_rddata = a_rddata[ATTR_BITS-1:ATTR_BITS-8];
            default:     io_rddata = 8'h00;
        endcase
    end

    for (genvar i = 0; i < ATTR_BITS; i++) begin : g_bit
        ram64x1d ram_i (
            .clk      (clk),
            .a_addr   (sprsel_r),
            .a_wrdata (a_wrdata[i]),
            .a_wren   (a_wren[i]),
            .a_rddata (a_rddata[i]),
            .b_addr   (spr_sel),
            .b_rddata (b_rddata[i])
        );
    end

    assign spr_attr = b_rddata;

endmodule

/* sprite_engine_chk.sv */
`timescale 1ns/1ps

module sprite_engine_chk (
    input logic clk,
    input logic reset,
    input logic line_start,
    input logic hit_push,
    input logic busy,
    input logic scan_done
);

    int failures = 0;

    // Done comes exactly as busy drops
    a_done_not_busy: assert property (@(posedge clk) disable iff (reset)
        scan_done |-> $fell(busy))
        else begin
            $error("scan_done without busy dropping");
            failures++;
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        scan_done |=> !scan_done)
        else begin
            $error("scan_done longer than one cycle");
            failures++;
        end

    a_push_busy: assert property (@(posedge clk) disable iff (reset)
        hit_push |-> busy && $past(busy || line_start))   // Scan started or running
        else begin
            $error("hit_push outside a scan");
            failures++;
        end

    // 64 sprite cycles before DONE
    a_done_latency: assert property (@(posedge clk) disable iff (reset)
        line_start ##1 (!line_start [*64]) |=> scan_done)
        else begin
            $error("scan_done not 65 edges after line_start");
            failures++;
        end

endmodule

bind sprite_scan_fsm sprite_engine_chk chk_i (
    .clk        (clk),
    .reset      (reset),
    .line_start (line_start),
    .hit_push   (hit_push),
    .busy       (busy),
    .scan_done  (scan_done)
);

/* sprite_engine_top.sv */
`timescale 1ns/1ps

module sprite_engine_top (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [3:0]                       io_addr,
    input  logic [7:0]                       io_wrdata,
    input  logic                             io_wren,
    output logic [7:0]                       io_rddata,
    input  logic                             line_start,
    input  logic [7:0]                       line,
    input  logic [sprite_pkg::HIT_IDX_W-1:0] hit_rd_idx,
    output sprite_pkg::hit_entry_t           hit_entry,
    output logic [sprite_pkg::HIT_CNT_W-1:0] hit_count,
    output logic                             overflow,
    output logic                             busy,
    output logic                             scan_done
);

    import sprite_pkg::*;

    logic [SPR_SEL_W-1:0] spr_index;
    spr_attr_t            spr_attr;
    logic                 last;
    logic                 cnt_clear;
    logic                 cnt_step;
    logic                 hit_clear;
    logic                 hit_push;
    hit_entry_t           hit_data;

    sprattr sprattr_i (
        .clk       (clk),
        .reset     (reset),
        .io_addr   (io_addr),
        .io_wrdata (io_wrdata),
        .io_wren   (io_wren),
        .io_rddata (io_rddata),
        .spr_sel   (spr_index),
        .spr_attr  (spr_attr)
    );

    sprite_index_counter counter_i (
        .clk   (clk),
        .reset (reset),
        .clear (cnt_clear),
        .step  (cnt_step),
        .index (spr_index),
        .last  (last)
    );

    sprite_scan_fsm fsm_i (
        .clk        (clk),
        .reset      (reset),
        .line_start (line_start),
        .line       (line),
        .spr_attr   (spr_attr),
        .last       (last),
        .cnt_clear  (cnt_clear),
        .cnt_step   (cnt_step),
        .hit_clear  (hit_clear),
        .hit_push   (hit_push),
        .hit_data   (hit_data),
        .busy       (busy),
        .scan_done  (scan_done)
    );

    sprite_hit_list hit_list_i (
        .clk      (clk),
        .reset    (reset),
        .clear    (hit_clear),
        .push     (hit_push),
        .entry    (hit_data),
        .rd_idx   (hit_rd_idx),
        .rd_entry (hit_entry),
        .count    (hit_count),
        .overflow (overflow)
    );

endmodule

/* sprite_hit_list.sv */
`timescale 1ns/1ps

module sprite_hit_list (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             clear,
    input  logic                             push,
    input  sprite_pkg::hit_entry_t           entry,
    input  logic [sprite_pkg::HIT_IDX_W-1:0] rd_idx,
    output sprite_pkg::hit_entry_t           rd_entry,
    output logic [sprite_pkg::HIT_CNT_W-1:0] count,
    output logic                             overflow
);

    import sprite_pkg::*;

    hit_entry_t entries [MAX_HITS];
    logic       room;

    assign room = (count < HIT_CNT_W'(MAX_HITS));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count    <= '0;
            overflow <= 1'b0;
        end else if (clear) begin
            count    <= '0;
            overflow <= 1'b0;
        end else if (push) begin
            if (room)
                count <= count + 1'b1;
            else
                overflow <= 1'b1;   // 17th hit and later are dropped
        end
    end

    always_ff @(posedge clk) begin
        if (push && room && !clear)
            entries[count[HIT_IDX_W-1:0]] <= entry;
    end

    assign rd_entry = entries[rd_idx];

endmodule

/* sprite_index_counter.sv */
`timescale 1ns/1ps

module sprite_index_counter (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             clear,
    input  logic                             step,
    output logic [sprite_pkg::SPR_SEL_W-1:0] index,
    output logic                             last
);

    import sprite_pkg::*;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            index <= '0;
        else if (clear)
            index <= '0;   // Restart wins over step
        else if (step)
            index <= index + 1'b1;
    end

    assign last = (index == SPR_SEL_W'(NUM_SPRITES - 1));

endmodule

/* sprite_pkg.sv */
package sprite_pkg;

    localparam int NUM_SPRITES = 64;
    localparam int SPR_SEL_W   = 6;
    localparam int MAX_HITS    = 16;
    localparam int HIT_IDX_W   = 4;
    localparam int HIT_CNT_W   = 5;     // Must hold MAX_HITS itself
    localparam int ATTR_BITS   = 33;

    localparam logic [3:0] REG_SPRSEL  = 4'h4;
    localparam logic [3:0] REG_SPRX_L  = 4'h5;
    localparam logic [3:0] REG_SPRX_H  = 4'h6;
    localparam logic [3:0] REG_SPRY    = 4'h7;
    localparam logic [3:0] REG_SPRIDX  = 4'h8;
    localparam logic [3:0] REG_SPRATTR = 4'h9;

    // Field order is the RAM bit order, top byte is the attribute register
    typedef struct packed {
        logic       enable;
        logic       prio;
        logic [1:0] palette;
        logic       h16;
        logic       vflip;
        logic       hflip;
        logic [8:0] idx;
        logic [7:0] y;
        logic [8:0] x;
    } spr_attr_t;

    // 32 bits with all fields kept
    typedef struct packed {
        logic [SPR_SEL_W-1:0] num;
        logic [8:0]           idx;
        logic [8:0]           x;
        logic [3:0]           row;
        logic [1:0]           palette;
        logic                 prio;
        logic                 hflip;
    } hit_entry_t;

endpackage

/* sprite_scan_fsm.sv */
`timescale 1ns/1ps

module sprite_scan_fsm (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  line_start,
    input  logic [7:0]            line,
    input  sprite_pkg::spr_attr_t spr_attr,
    input  logic                  last,
    output logic                  cnt_clear,
    output logic                  cnt_step,
    output logic                  hit_clear,
    output logic                  hit_push,
    output sprite_pkg::hit_entry_t hit_data,
    output logic                  busy,
    output logic                  scan_done
);

    import sprite_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SCAN,
        DONE
    } state_t;

    state_t               state;
    logic [7:0]           line_q;
    logic [SPR_SEL_W-1:0] spr_num;
    logic [7:0]           diff;
    logic [7:0]           height;
    logic                 hit;
    logic [3:0]           row;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= IDLE;
            spr_num <= '0;
        end else if (line_start) begin
            state   <= SCAN;   // Also restarts a running scan
            spr_num <= '0;
        end else begin
            case (state)
                SCAN: begin
                    spr_num <= spr_num + 1'b1;
                    if (last)
                        state <= DONE;
                end
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (line_start)
            line_q <= line;
    end

    // Y test with wrap past line 255
    assign diff   = line_q - spr_attr.y;
    assign height = spr_attr.h16 ? 8'd16 : 8'd8;
    assign hit    = spr_attr.enable && (diff < height);
    assign row    = spr_attr.vflip ? 4'(height - 8'd1 - diff) : diff[3:0];

    always_comb begin
        hit_data.num     = spr_num;
        hit_data.idx     = spr_attr.idx;
        hit_data.x       = spr_attr.x;
        hit_data.row     = row;
        hit_data.palette = spr_attr.palette;
        hit_data.prio    = spr_attr.prio;
        hit_data.hflip   = spr_attr.hflip;
    end

    assign cnt_clear = line_start;
    assign hit_clear = line_start;
    assign cnt_step  = (state == SCAN);
    assign hit_push  = (state == SCAN) && hit;
    assign busy      = (state == SCAN);
    assign scan_done = (state == DONE);

endmodule

/* sprite_vectors.txt */
# W addr data | R addr expect | S first count x y idx attr | L line (all hex)
# C count overflow | H slot entry | Q first_sprite count
S 00 40 000 00 00 00
W 4 03
R 4 03
W 5 a5
W 6 ff
W 7 3c
W 8 5a
W 9 c7
R 5 a5
R 6 01
R 7 3c
R 8 5a
R 9 c7
R 0 00
W 4 02
R 9 00
S 04 01 000 40 00 7e
S 05 01 0f0 35 12 bc
S 06 01 0aa 41 77 80
S 07 01 007 39 07 81
S 08 01 000 38 00 80
L 40
C 03 0
H 0 0eb5a533
H 1 1424f04c
H 2 1e0e0770
S 0a 01 010 fc 22 a8
S 0b 01 000 05 00 7e
S 0c 01 020 f8 33 9c
S 0d 01 130 02 44 82
S 0e 01 1ff 05 ff 84
L 05
C 04 0
H 0 28441098
H 1 30662024
H 2 34893031
H 3 39ffff70
S 20 14 000 7c 00 88
L 80
C 10 1
Q 20 10
L 05
C 04 0

/* tb_sprite_engine.sv */
`timescale 1ns/1ps

module tb_sprite_engine;

    import sprite_pkg::*;

    logic                 clk;
    logic                 reset;
    logic [3:0]           io_addr;
    logic [7:0]           io_wrdata;
    logic                 io_wren;
    logic [7:0]           io_rddata;
    logic                 line_start;
    logic [7:0]           line;
    logic [HIT_IDX_W-1:0] hit_rd_idx;
    hit_entry_t           hit_entry;
    logic [HIT_CNT_W-1:0] hit_count;
    logic                 overflow;
    logic                 busy;
    logic                 scan_done;
    int                   errors;
    int                   timeouts;
    int                   fd;

    sprite_engine_top dut_i (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic reg_write(input logic [3:0] addr, input logic [7:0] data);
        @(posedge clk);
        io_addr   <= addr;
        io_wrdata <= data;
        io_wren   <= 1'b1;
        @(posedge clk);
        io_wren   <= 1'b0;
    endtask

    task automatic reg_check(input logic [3:0] addr, input logic [7:0] expected);
        @(posedge clk);
        io_addr <= addr;
        @(negedge clk);
        if (io_rddata !== expected) begin
            $display("ERROR %0t: reg %h read %h, expected %h", $time, addr, io_rddata, expected);
            errors++;
        end
    endtask

    task automatic sprites_write(input logic [5:0] first, input int count, input logic [8:0] x,
                                 input logic [7:0] y, input logic [7:0] idx,
                                 input logic [7:0] attr);
        for (int k = 0; k < count; k++) begin
            reg_write(REG_SPRSEL, 8'(first + k));
            reg_write(REG_SPRX_L, x[7:0]);
            reg_write(REG_SPRX_H, {7'b0, x[8]});
            reg_write(REG_SPRY, y);
            reg_write(REG_SPRIDX, idx);
            reg_write(REG_SPRATTR, attr);
        end
    endtask

    task automatic line_scan(input logic [7:0] ln);
        int cycles;
        int busy_cycles;
        @(posedge clk);
        line_start <= 1'b1;
        line       <= ln;
        @(posedge clk);
        line_start <= 1'b0;
        cycles      = 0;
        busy_cycles = 0;
        do begin
            @(negedge clk);
            cycles++;   // Edge that will sample the outputs
            if (busy)
                busy_cycles++;
        end while (!scan_done && cycles < 200);
        if (!scan_done) begin
            $display("Timeout: no scan_done within 200 cycles for line %h", ln);
            timeouts++;
        end else if (cycles != 65 || busy_cycles != 64 || busy) begin
            $display("ERROR %0t: scan_done after %0d cycles, busy for %0d, busy now %b",
                     $time, cycles, busy_cycles, busy);
            errors++;
        end
    endtask

    task automatic entry_check(input logic [3:0] slot, input logic [31:0] expected);
        @(posedge clk);
        hit_rd_idx <= slot;
        @(negedge clk);
        if (hit_entry !== expected) begin
            $display("ERROR %0t: hit slot %0d is %h, expected %h",
                     $time, slot, hit_entry, expected);
            errors++;
        end
    endtask

    initial begin
        logic [7:0]       cmd;
        logic [31:0]      a1, a2, a3, a4, a5, a6;
        logic [8*128-1:0] rest;
        int               r;
        errors     = 0;
        timeouts   = 0;
        reset      = 1'b1;
        io_addr    = '0;
        io_wrdata  = '0;
        io_wren    = 1'b0;
        line_start = 1'b0;
        line       = '0;
        hit_rd_idx = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        fd = $fopen("sprite_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open sprite_vectors.txt");
            errors++;
        end else begin
            while ($fscanf(fd, " %c", cmd) == 1) begin
                case (cmd)
                    "#": r = $fgets(rest, fd);
                    "W": begin
                        r = $fscanf(fd, "%h %h", a1, a2);
                        reg_write(a1[3:0], a2[7:0]);
                    end
                    "R": begin
                        r = $fscanf(fd, "%h %h", a1, a2);
                        reg_check(a1[3:0], a2[7:0]);
                    end
                    "S": begin
                        r = $fscanf(fd, "%h %h %h %h %h %h", a1, a2, a3, a4, a5, a6);
                        sprites_write(a1[5:0], a2, a3[8:0], a4[7:0], a5[7:0], a6[7:0]);
                    end
                    "L": begin
                        r = $fscanf(fd, "%h", a1);
                        line_scan(a1[7:0]);
                    end
                    "C": begin
                        r = $fscanf(fd, "%h %h", a1, a2);
                        @(negedge clk);
                        if (hit_count !== a1[4:0] || overflow !== a2[0]) begin
                            $display("ERROR %0t: count %0d overflow %b, expected %0d %b",
                                     $time, hit_count, overflow, a1[4:0], a2[0]);
                            errors++;
                        end
                    end
                    "H": begin
                        r = $fscanf(fd, "%h %h", a1, a2);
                        entry_check(a1[3:0], a2);
                    end
                    "Q": begin
                        r = $fscanf(fd, "%h %h", a1, a2);
                        for (int i = 0; i < a2; i++) begin   // Ascending sprite numbers
                            @(posedge clk);
                            hit_rd_idx <= 4'(i);
                            @(negedge clk);
                            if (hit_entry.num !== 6'(a1 + i)) begin
                                $display("ERROR %0t: hit slot %0d holds sprite %h, expected %h",
                                         $time, i, hit_entry.num, 6'(a1 + i));
                                errors++;
                            end
                        end
                    end
                    default: begin
                        $display("Unknown command %c in the vectors file", cmd);
                        errors++;
                    end
                endcase
            end
            $fclose(fd);
        end
        $display("Checks done: %0d errors, %0d timeouts, %0d assertion failures",
                 errors, timeouts, dut_i.fsm_i.chk_i.failures);
        if (errors == 0 && timeouts == 0 && dut_i.fsm_i.chk_i.failures == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* verilog.f */
sprite_pkg.sv
ram64x1d.sv
sprattr.sv
sprite_index_counter.sv
sprite_scan_fsm.sv
sprite_hit_list.sv
sprite_engine_top.sv
sprite_engine_chk.sv
tb_sprite_engine.sv
